// ==== hdl/core_types_pkg.sv ====
package core_types_pkg;

    // ====================
    // Architectural sizes
    // ====================

    // Width of one integer register and of every operand
    localparam int DATA_WIDTH = 32;

    // Number of architectural integer registers, x0 included
    localparam int REG_COUNT = 32;

    // ====================
    // Shared field types
    // ====================

    // Operand, register value or instruction address
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Architectural register number, 0 selects the hardwired zero
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // Exception cause carried by the instruction packet
    typedef logic [4:0] exc_vector_t;

endpackage

// ==== hdl/exec_units_pkg.sv ====
package exec_units_pkg;

    // ====================
    // Unit select encoding
    // ====================

    // One-hot choice of functional unit, at most one bit set per instruction
    typedef logic [3:0] exu_sel_t;

    // Bit positions inside exu_sel_t
    localparam int EXU_ALU = 0;
    localparam int EXU_MUL = 1;
    localparam int EXU_DIV = 2;
    localparam int EXU_CSR = 3;

    // ====================
    // Fixed unit latencies
    // ====================

    // Cycles from issue to the writeback pulse of the ALU
    localparam int ALU_LATENCY = 1;

    // The CSR unit answers one cycle after issue, its done pulse follows later
    localparam int CSR_LATENCY = 1;

    // Length of the result reservation register
    // Every unit latency, the parameterized ones too, has to stay below this
    localparam int SLOT_DEPTH = 16;

endpackage

// ==== hdl/register_file.sv ====
module register_file import core_types_pkg::*; (
    input  logic             clk_i,

    // Write port, fed from the writeback bus
    input  logic             write_i,
    input  reg_idx_t         write_reg_i,
    input  data_word_t       write_data_i,

    // Two asynchronous read ports, one per source operand
    input  reg_idx_t   [1:0] read_reg_i,
    output data_word_t [1:0] read_data_o
);

    // Storage for all registers, entry 0 is never written
    data_word_t regs_q [REG_COUNT];

    // Writes land on the clock edge
    // A write to x0 is dropped so that the entry stays at its initial value
    always_ff @(posedge clk_i) begin
        if (write_i && (write_reg_i != '0)) begin
            regs_q[write_reg_i] <= write_data_i;
        end
    end

    // Reads are combinational, x0 is forced to zero regardless of array contents
    // A same-cycle write is not visible here, the operand selector forwards it
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (read_reg_i[i] == '0) begin
                read_data_o[i] = '0;
            end else begin
                read_data_o[i] = regs_q[read_reg_i[i]];
            end
        end
    end

endmodule

// ==== hdl/scoreboard.sv ====
module scoreboard import core_types_pkg::*; import exec_units_pkg::*; #(
    parameter int MUL_LATENCY = 3,
    parameter int DIV_LATENCY = 8
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           issue_i,

    // Decoded instruction
    input  exu_sel_t       exu_sel_i,
    input  reg_idx_t [1:0] src_reg_i,
    input  logic     [1:0] src_used_i,
    input  reg_idx_t       dest_reg_i,

    // Writeback pulse from the units
    input  logic           writeback_i,
    input  reg_idx_t       writeback_reg_i,

    // Hazard verdict toward the control
    output logic           raw_hazard_o,
    output logic           struct_hazard_o,
    output logic           slot_conflict_o,
    output logic           units_idle_o
);

    localparam int SLOT_IDX_W = $clog2(SLOT_DEPTH);
    localparam int DIV_CNT_W  = $clog2(DIV_LATENCY + 1);

    logic [REG_COUNT-1:0]  pending_q;
    logic [SLOT_DEPTH-1:0] slot_q;
    logic [DIV_CNT_W-1:0]  div_cnt_q;
    logic [SLOT_IDX_W-1:0] req_latency;

    // ====================
    // Hazard evaluation
    // ====================

    // A source waits on its pending bit unless the result shows up right now
    // In that case the operand selector picks it off the writeback bus
    always_comb begin
        raw_hazard_o = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (src_used_i[i] && pending_q[src_reg_i[i]] &&
                !(writeback_i && (writeback_reg_i == src_reg_i[i]))) begin
                raw_hazard_o = 1'b1;
            end
        end
    end

    // Latency of the requested unit, a zero select reserves nothing
    always_comb begin
        if (exu_sel_i[EXU_ALU]) begin
            req_latency = SLOT_IDX_W'(ALU_LATENCY);
        end else if (exu_sel_i[EXU_MUL]) begin
            req_latency = SLOT_IDX_W'(MUL_LATENCY);
        end else if (exu_sel_i[EXU_DIV]) begin
            req_latency = SLOT_IDX_W'(DIV_LATENCY);
        end else begin
            req_latency = SLOT_IDX_W'(CSR_LATENCY);
        end
    end

    // Slot i holds a result that reaches the writeback port i cycles from now
    assign slot_conflict_o = (exu_sel_i != '0) && slot_q[req_latency];

    // The divider is not pipelined, a second DIV waits for the counter to drain
    assign struct_hazard_o = exu_sel_i[EXU_DIV] && (div_cnt_q != '0);

    // Nothing in flight and no result outstanding
    assign units_idle_o = (pending_q == '0) && (slot_q == '0) && (div_cnt_q == '0);

    // ====================
    // State update
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            pending_q <= '0;
            slot_q    <= '0;
            div_cnt_q <= '0;
        end else begin
            // Pending mask, a new reservation wins over a writeback of the same register
            for (int r = 0; r < REG_COUNT; r++) begin
                if (issue_i && (dest_reg_i != '0) && (dest_reg_i == reg_idx_t'(r))) begin
                    pending_q[r] <= 1'b1;
                end else if (writeback_i && (writeback_reg_i == reg_idx_t'(r))) begin
                    pending_q[r] <= 1'b0;
                end
            end

            // Slots move one step closer each cycle
            // Seen from the next cycle the new result is one step nearer than its latency
            for (int s = 0; s < SLOT_DEPTH; s++) begin
                if (issue_i && (exu_sel_i != '0) && (s == int'(req_latency) - 1)) begin
                    slot_q[s] <= 1'b1;
                end else if (s == SLOT_DEPTH - 1) begin
                    slot_q[s] <= 1'b0;
                end else begin
                    slot_q[s] <= slot_q[s+1];
                end
            end

            // Divider busy window
            if (issue_i && exu_sel_i[EXU_DIV]) begin
                div_cnt_q <= DIV_CNT_W'(DIV_LATENCY);
            end else if (div_cnt_q != '0) begin
                div_cnt_q <= div_cnt_q - 1'b1;
            end
        end
    end

    // The control must never let an instruction out against a hazard verdict
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_i |-> !(raw_hazard_o || struct_hazard_o || slot_conflict_o));

    // Results only come back for registers some earlier issue reserved
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        writeback_i && (writeback_reg_i != '0) |-> pending_q[writeback_reg_i]);

endmodule

// ==== hdl/operand_select.sv ====
module operand_select import core_types_pkg::*; (
    input  reg_idx_t   [1:0] src_reg_i,
    input  data_word_t [1:0] reg_data_i,
    input  data_word_t [1:0] immediate_i,
    input  logic       [1:0] immediate_valid_i,
    input  logic             writeback_i,
    input  reg_idx_t         writeback_reg_i,
    input  data_word_t       writeback_data_i,
    input  logic             save_next_pc_i,
    input  logic             compressed_i,
    output data_word_t [1:0] operand_o,
    output logic       [1:0] immediate_valid_o
);

    // Link increments for jump-and-link, the ALU adds them to the packet address
    localparam data_word_t LINK_INC      = data_word_t'(4);
    localparam data_word_t LINK_INC_COMP = data_word_t'(2);

    data_word_t [1:0] src_value;

    // Register value with the same-cycle writeback forwarded over it
    // x0 is never forwarded since its write is dropped by the register file
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (writeback_i && (writeback_reg_i == src_reg_i[i]) && (src_reg_i[i] != '0)) begin
                src_value[i] = writeback_data_i;
            end else begin
                src_value[i] = reg_data_i[i];
            end
        end
    end

    always_comb begin
        if (save_next_pc_i) begin
            // JAL and JALR: rs1 goes on operand 0 for the target, operand 1 is the step
            operand_o[0]      = src_value[0];
            operand_o[1]      = compressed_i ? LINK_INC_COMP : LINK_INC;
            immediate_valid_o = 2'b10;
        end else begin
            // An immediate takes the slot of its register operand
            for (int i = 0; i < 2; i++) begin
                operand_o[i] = immediate_valid_i[i] ? immediate_i[i] : src_value[i];
            end
            immediate_valid_o = immediate_valid_i;
        end
    end

endmodule

// ==== hdl/rob_tag_generator.sv ====
module rob_tag_generator #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         branch_flush_i,
    input  logic                         issue_i,
    output logic [$clog2(ROB_DEPTH)-1:0] tag_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam logic [TAG_W-1:0] LAST_TAG = TAG_W'(ROB_DEPTH - 1);

    logic [TAG_W-1:0] tag_q;
    logic             issued_q;

    // The tag shown is the one the instruction issuing now receives
    assign tag_o = tag_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            tag_q    <= '0;
            issued_q <= 1'b0;
        end else begin
            issued_q <= issue_i;

            if (branch_flush_i) begin
                // Only the instruction issued last cycle is on the wrong path
                if (issued_q) begin
                    tag_q <= (tag_q == '0) ? LAST_TAG : tag_q - 1'b1;
                end
            end else if (issue_i) begin
                // Wrap by hand so that a depth that is not a power of two works too
                tag_q <= (tag_q == LAST_TAG) ? '0 : tag_q + 1'b1;
            end
        end
    end

    // The branch unit resolves before the front end can offer the next instruction
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(issue_i && branch_flush_i));

endmodule

// ==== hdl/issue_control.sv ====
module issue_control import exec_units_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     instr_valid_i,
    input  exu_sel_t exu_sel_i,
    input  logic     fence_i,
    input  logic     csr_done_i,
    input  logic     stop_tag_i,
    input  logic     pipeline_empty_i,
    input  logic     raw_hazard_i,
    input  logic     struct_hazard_i,
    input  logic     slot_conflict_i,
    input  logic     units_idle_i,
    output logic     issue_o,
    output logic     stall_o
);

    logic csr_wait_q;
    logic hazard;
    logic fence_wait;

    // ====================
    // Stall decision
    // ====================

    // Hazard levels only mean something for a valid instruction
    assign hazard = raw_hazard_i | struct_hazard_i | slot_conflict_i;

    // A fence waits until both our own units and the downstream ones have drained
    assign fence_wait = fence_i & (~units_idle_i | ~pipeline_empty_i);

    // CSR wait and ROB back-pressure hold the front end even without an instruction
    assign stall_o = (instr_valid_i & (hazard | fence_wait)) | csr_wait_q | stop_tag_i;

    // Flush kills the instruction in this cycle without raising stall
    assign issue_o = instr_valid_i & ~stall_o & ~flush_i;

    // ====================
    // CSR wait flag
    // ====================

    // Set by a CSR issue and cleared by the done pulse
    // So the stall drops in the cycle after csr_done_i
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            csr_wait_q <= 1'b0;
        end else if (csr_done_i) begin
            csr_wait_q <= 1'b0;
        end else if (issue_o && exu_sel_i[EXU_CSR]) begin
            csr_wait_q <= 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(issue_o && stall_o));

endmodule

// ==== hdl/issue_stage.sv ====
module issue_stage import core_types_pkg::*; import exec_units_pkg::*; #(
    parameter int ROB_DEPTH   = 32,
    parameter int MUL_LATENCY = 3,
    parameter int DIV_LATENCY = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Decoded instruction from the front end
    input  logic                         instr_valid_i,
    input  exu_sel_t                     exu_sel_i,
    input  reg_idx_t   [1:0]             src_reg_i,
    input  logic       [1:0]             src_used_i,
    input  reg_idx_t                     dest_reg_i,
    input  data_word_t [1:0]             immediate_i,
    input  logic       [1:0]             immediate_valid_i,
    input  logic                         save_next_pc_i,
    input  logic                         compressed_i,
    input  logic                         fence_i,
    input  data_word_t                   instr_addr_i,
    input  logic                         exception_i,
    input  exc_vector_t                  exception_vector_i,

    // Results coming back from the units
    input  logic                         writeback_i,
    input  reg_idx_t                     writeback_reg_i,
    input  data_word_t                   writeback_data_i,
    input  logic                         csr_done_i,

    // Pipeline control
    input  logic                         flush_i,
    input  logic                         branch_flush_i,
    input  logic                         stop_tag_i,
    input  logic                         pipeline_empty_i,

    output logic                         issue_o,
    output logic                         stall_o,
    output data_word_t [1:0]             operand_o,
    output logic       [1:0]             immediate_valid_o,
    output exu_sel_t                     exu_sel_o,

    // Instruction packet
    output logic [$clog2(ROB_DEPTH)-1:0] tag_o,
    output reg_idx_t                     dest_reg_o,
    output data_word_t                   instr_addr_o,
    output logic                         compressed_o,
    output logic                         exception_o,
    output exc_vector_t                  exception_vector_o
);

    logic             issue;
    logic             raw_hazard;
    logic             struct_hazard;
    logic             slot_conflict;
    logic             units_idle;
    data_word_t [1:0] reg_data;

    // ====================
    // Control
    // ====================

    issue_control u_issue_control (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .instr_valid_i    (instr_valid_i),
        .exu_sel_i        (exu_sel_i),
        .fence_i          (fence_i),
        .csr_done_i       (csr_done_i),
        .stop_tag_i       (stop_tag_i),
        .pipeline_empty_i (pipeline_empty_i),
        .raw_hazard_i     (raw_hazard),
        .struct_hazard_i  (struct_hazard),
        .slot_conflict_i  (slot_conflict),
        .units_idle_i     (units_idle),
        .issue_o          (issue),
        .stall_o          (stall_o)
    );

    scoreboard #(
        .MUL_LATENCY (MUL_LATENCY),
        .DIV_LATENCY (DIV_LATENCY)
    ) u_scoreboard (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_i         (issue),
        .exu_sel_i       (exu_sel_i),
        .src_reg_i       (src_reg_i),
        .src_used_i      (src_used_i),
        .dest_reg_i      (dest_reg_i),
        .writeback_i     (writeback_i),
        .writeback_reg_i (writeback_reg_i),
        .raw_hazard_o    (raw_hazard),
        .struct_hazard_o (struct_hazard),
        .slot_conflict_o (slot_conflict),
        .units_idle_o    (units_idle)
    );

    rob_tag_generator #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob_tag_generator (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .branch_flush_i (branch_flush_i),
        .issue_i        (issue),
        .tag_o          (tag_o)
    );

    // ====================
    // Datapath
    // ====================

    // The register file is written straight from the writeback bus
    register_file u_register_file (
        .clk_i        (clk_i),
        .write_i      (writeback_i),
        .write_reg_i  (writeback_reg_i),
        .write_data_i (writeback_data_i),
        .read_reg_i   (src_reg_i),
        .read_data_o  (reg_data)
    );

    operand_select u_operand_select (
        .src_reg_i         (src_reg_i),
        .reg_data_i        (reg_data),
        .immediate_i       (immediate_i),
        .immediate_valid_i (immediate_valid_i),
        .writeback_i       (writeback_i),
        .writeback_reg_i   (writeback_reg_i),
        .writeback_data_i  (writeback_data_i),
        .save_next_pc_i    (save_next_pc_i),
        .compressed_i      (compressed_i),
        .operand_o         (operand_o),
        .immediate_valid_o (immediate_valid_o)
    );

    // Packet fields travel with the instruction, valid while issue_o is high
    assign issue_o            = issue;
    assign exu_sel_o          = exu_sel_i;
    assign dest_reg_o         = dest_reg_i;
    assign instr_addr_o       = instr_addr_i;
    assign compressed_o       = compressed_i;
    assign exception_o        = exception_i;
    assign exception_vector_o = exception_vector_i;

endmodule

// ==== testbench/issue_tb_checks.svh ====
`ifndef ISSUE_TB_CHECKS_SVH
`define ISSUE_TB_CHECKS_SVH

// ====================
// Compare tasks
// ====================

// Each task counts one check and reports a mismatch as soon as it is seen
// The counters live in the including testbench module

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
endtask

// Tag width follows the ROB depth of the DUT instance
task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
endtask

task automatic check_exc(input string name, input exc_vector_t exp, input exc_vector_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_exu(input string name, input exu_sel_t exp, input exu_sel_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

`endif

// ==== testbench/issue_stage_tb.sv ====
module issue_stage_tb import core_types_pkg::*; import exec_units_pkg::*; ();

    localparam int ROB_DEPTH    = 32;
    localparam int TAG_W        = $clog2(ROB_DEPTH);
    localparam int N_FIELDS     = 13;
    localparam int MAX_LINES    = 128;
    localparam int RESET_CYCLES = 16;

    typedef logic [TAG_W-1:0] tag_t;

    logic             clk;
    logic             rst_n;
    logic             instr_valid;
    exu_sel_t         exu_sel;
    reg_idx_t   [1:0] src_reg;
    logic       [1:0] src_used;
    reg_idx_t         dest_reg;
    data_word_t [1:0] immediate;
    logic       [1:0] immediate_valid;
    logic             save_next_pc;
    logic             compressed;
    logic             fence;
    data_word_t       instr_addr;
    logic             exception;
    exc_vector_t      exception_vector;
    logic             writeback;
    reg_idx_t         writeback_reg;
    data_word_t       writeback_data;
    logic             csr_done;
    logic             flush;
    logic             branch_flush;
    logic             stop_tag;
    logic             pipeline_empty;

    logic             issue;
    logic             stall;
    data_word_t [1:0] operand;
    logic       [1:0] immediate_valid_out;
    exu_sel_t         exu_sel_out;
    tag_t             tag;
    reg_idx_t         dest_reg_out;
    data_word_t       instr_addr_out;
    logic             compressed_out;
    logic             exception_out;
    exc_vector_t      exception_vector_out;

    // One line of the data file occupies N_FIELDS consecutive words
    logic [31:0] vec_mem [N_FIELDS*MAX_LINES];

    int check_count;
    int error_count;
    int group_count;
    int cycle_count;
    int cycle_limit;

    `include "issue_tb_checks.svh"

    issue_stage #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut0 (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .instr_valid_i      (instr_valid),
        .exu_sel_i          (exu_sel),
        .src_reg_i          (src_reg),
        .src_used_i         (src_used),
        .dest_reg_i         (dest_reg),
        .immediate_i        (immediate),
        .immediate_valid_i  (immediate_valid),
        .save_next_pc_i     (save_next_pc),
        .compressed_i       (compressed),
        .fence_i            (fence),
        .instr_addr_i       (instr_addr),
        .exception_i        (exception),
        .exception_vector_i (exception_vector),
        .writeback_i        (writeback),
        .writeback_reg_i    (writeback_reg),
        .writeback_data_i   (writeback_data),
        .csr_done_i         (csr_done),
        .flush_i            (flush),
        .branch_flush_i     (branch_flush),
        .stop_tag_i         (stop_tag),
        .pipeline_empty_i   (pipeline_empty),
        .issue_o            (issue),
        .stall_o            (stall),
        .operand_o          (operand),
        .immediate_valid_o  (immediate_valid_out),
        .exu_sel_o          (exu_sel_out),
        .tag_o              (tag),
        .dest_reg_o         (dest_reg_out),
        .instr_addr_o       (instr_addr_out),
        .compressed_o       (compressed_out),
        .exception_o        (exception_out),
        .exception_vector_o (exception_vector_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Guard against a run that never reaches its end
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the vector loop did not finish", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // ====================
    // Stimulus
    // ====================

    // Inputs for a cycle without an instruction or a writeback
    task automatic drive_idle();
        instr_valid      = 1'b0;
        save_next_pc     = 1'b0;
        compressed       = 1'b0;
        fence            = 1'b0;
        exception        = 1'b0;
        writeback        = 1'b0;
        csr_done         = 1'b0;
        flush            = 1'b0;
        branch_flush     = 1'b0;
        stop_tag         = 1'b0;
        pipeline_empty   = 1'b1;
        exu_sel          = '0;
        src_reg          = '0;
        dest_reg         = '0;
        writeback_reg    = '0;
        src_used         = '0;
        immediate_valid  = '0;
        immediate        = '0;
        writeback_data   = '0;
        instr_addr       = '0;
        exception_vector = '0;
    endtask

    // Unpack one line onto the DUT inputs
    task automatic drive_line(input int ln);
        int          b;
        logic [31:0] ctl;
        logic [31:0] regs;
        logic [3:0]  sel;
        b    = ln * N_FIELDS;
        ctl  = vec_mem[b+1];
        regs = vec_mem[b+3];
        sel  = vec_mem[b+4][3:0];
        instr_valid      = ctl[0];
        save_next_pc     = ctl[1];
        compressed       = ctl[2];
        fence            = ctl[3];
        exception        = ctl[4];
        writeback        = ctl[5];
        csr_done         = ctl[6];
        flush            = ctl[7];
        branch_flush     = ctl[8];
        stop_tag         = ctl[9];
        pipeline_empty   = ctl[10];
        exu_sel          = vec_mem[b+2][3:0];
        src_reg[0]       = regs[28:24];
        src_reg[1]       = regs[20:16];
        dest_reg         = regs[12:8];
        writeback_reg    = regs[4:0];
        src_used         = sel[1:0];
        immediate_valid  = sel[3:2];
        immediate[0]     = vec_mem[b+5];
        immediate[1]     = vec_mem[b+6];
        writeback_data   = vec_mem[b+7];
        instr_addr       = vec_mem[b+8];
        exception_vector = vec_mem[b+9][4:0];
    endtask

    // Issue and stall are always compared and the rest only while an instruction leaves
    task automatic compare_line(input int ln);
        int          b;
        logic [31:0] exp;
        b   = ln * N_FIELDS;
        exp = vec_mem[b+10];
        check_bit("issue_o", exp[0], issue);
        check_bit("stall_o", exp[1], stall);
        if (exp[0]) begin
            check_word("operand_o[0]", vec_mem[b+11], operand[0]);
            check_word("operand_o[1]", vec_mem[b+12], operand[1]);
            check_bit("immediate_valid_o[0]", exp[2], immediate_valid_out[0]);
            check_bit("immediate_valid_o[1]", exp[3], immediate_valid_out[1]);
            check_tag("tag_o", exp[8 +: TAG_W], tag);
            // Packet fields must equal what the front end presented
            check_exu("exu_sel_o", exu_sel, exu_sel_out);
            check_reg("dest_reg_o", dest_reg, dest_reg_out);
            check_word("instr_addr_o", instr_addr, instr_addr_out);
            check_bit("compressed_o", compressed, compressed_out);
            check_bit("exception_o", exception, exception_out);
            check_exc("exception_vector_o", exception_vector, exception_vector_out);
        end
    endtask

    task automatic report_group(input int grp, input int checks0, input int errors0);
        group_count++;
        $display("Group %0d finished: %0d checks, %0d errors", grp,
                 check_count - checks0, error_count - errors0);
    endtask

    initial begin
        int n_lines;
        int cur_grp;
        int checks0;
        int errors0;
        rst_n       = 1'b0;
        check_count = 0;
        error_count = 0;
        group_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        cur_grp     = 0;
        checks0     = 0;
        errors0     = 0;
        n_lines     = 0;
        drive_idle();

        $readmemh("testbench/issue_tests.txt", vec_mem);
        // A line with group 0 closes the list
        while (n_lines < MAX_LINES - 1 && vec_mem[n_lines*N_FIELDS] != 0) begin
            n_lines++;
        end
        cycle_limit = n_lines + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        for (int ln = 0; ln < n_lines; ln++) begin
            @(negedge clk);
            rst_n = 1'b1;
            if (vec_mem[ln*N_FIELDS] != cur_grp) begin
                if (cur_grp != 0) begin
                    report_group(cur_grp, checks0, errors0);
                end
                cur_grp = vec_mem[ln*N_FIELDS];
                checks0 = check_count;
                errors0 = error_count;
            end
            drive_line(ln);
            // Outputs are combinational and settle well before the rising edge
            #10;
            compare_line(ln);
        end
        if (cur_grp != 0) begin
            report_group(cur_grp, checks0, errors0);
        end

        $display("Groups: %0d, checks: %0d, errors: %0d", group_count, check_count, error_count);
        if (n_lines == 0) begin
            $display("No test vectors were read from the data file");
            $display("Test failures found");
        end else if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/issue_tests.txt ====
// grp ctl exu regs(src0 src1 dest wbreg) uim(immv[3:2] used[1:0]) imm0 imm1 wbdata addr excv
// exp(tag[12:8] immv[3:2] stall[1] issue[0]) op0 op1; ctl bits in tb drive order, 0 ends
// Group 1 operands and forwarding
1 401 1 00000500 C 11 22 0 1000 0 00D 11 22
1 421 1 05000605 3 0 0 A5A5 1004 0 101 A5A5 0
1 421 1 06050706 3 0 0 66 1008 0 201 66 A5A5
1 427 1 06000107 1 0 0 77 100C 0 309 66 2
1 423 1 01000001 1 0 0 1234 1010 0 409 1234 4
1 401 1 07000000 9 0 55 0 1014 0 509 77 55
// Group 2 RAW stall on a MUL result
2 401 2 00000800 0 0 0 0 1018 0 601 0 0
2 401 1 08000900 1 0 0 0 101C 0 002 0 0
2 401 1 08000900 1 0 0 0 101C 0 002 0 0
2 421 1 08000908 1 0 0 888 101C 0 701 888 0
2 420 0 00000009 0 0 0 99 0 0 000 0 0
// Group 3 divider busy and result slot collision
3 401 4 00000000 0 0 0 0 1020 0 801 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 002 0 0
3 401 4 00000000 0 0 0 0 1024 0 901 0 0
3 401 2 00000000 0 0 0 0 1028 0 A01 0 0
3 400 0 00000000 0 0 0 0 0 0 000 0 0
3 401 1 00000000 0 0 0 0 102C 0 002 0 0
3 401 1 00000000 0 0 0 0 102C 0 B01 0 0
// Group 4 ROB tags
4 401 1 00000000 0 0 0 0 1030 0 C01 0 0
4 401 1 00000000 0 0 0 0 1034 0 D01 0 0
4 500 0 00000000 0 0 0 0 0 0 000 0 0
4 401 1 00000000 0 0 0 0 1034 0 D01 0 0
4 481 1 00000000 0 0 0 0 1038 0 000 0 0
4 401 1 00000000 0 0 0 0 103C 0 001 0 0
4 601 1 00000000 0 0 0 0 1040 0 002 0 0
4 401 1 00000000 0 0 0 0 1040 0 101 0 0
// Group 5 CSR wait, fence and back-pressure
5 401 8 00000000 0 0 0 0 1044 0 201 0 0
5 401 1 00000000 0 0 0 0 1048 0 002 0 0
5 441 1 00000000 0 0 0 0 1048 0 002 0 0
5 401 1 00000000 0 0 0 0 1048 0 301 0 0
5 401 4 00000000 0 0 0 0 104C 0 401 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 002 0 0
5 409 0 00000000 0 0 0 0 1050 0 501 0 0
5 615 1 00000300 C 1 2 0 BEEF B 002 1 2
5 415 1 00000300 C 1 2 0 BEEF B 60D 1 2
0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== all.f ====
+incdir+testbench
hdl/core_types_pkg.sv
hdl/exec_units_pkg.sv
hdl/register_file.sv
hdl/scoreboard.sv
hdl/operand_select.sv
hdl/rob_tag_generator.sv
hdl/issue_control.sv
hdl/issue_stage.sv
testbench/issue_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

# Run from the project root so the data file path resolves
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module issue_stage_tb \
    -f all.f \
    -o issue_sim

./obj_dir/issue_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
